/* build.f */
+incdir+logic
logic/aluPkg.sv
logic/aluIf.sv
logic/addSub.sv
logic/alu.sv
logic/regFile.sv
logic/execControl.sv
logic/aluCore.sv
tb/aluCore_props.sv
tb/aluCoreTb.sv

/* tb/aluCoreTb.sv */
`default_nettype none

`include "alu_cfg.svh"

module aluCoreTb;
	import aluPkg::*;

	localparam int numOps = 60;
	// Upper bound on APB transfers, each CMP adds a full register sweep.
	localparam int maxTransfers = 18 + 33 + (numOps + 20) * 22 + 30;

	logic     clk;
	logic     rstN;
	logic     psel;
	logic     penable;
	logic     pwrite;
	apbAddr_t paddr;
	word_t    pwdata;
	word_t    prdata;
	logic     pready;
	logic     pslverr;

	// Reference model of the programmer-visible state.
	word_t    model [`REG_COUNT];
	flags_t   flagsModel;
	word_t    lastInstrModel;
	integer   seed;
	int       errors;
	int       checks;

	aluCore dut0 (
		.clk     (clk),
		.rstN    (rstN),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (maxTransfers * 20) @(posedge clk);
		$display("Timeout: the APB transfers did not finish in the allowed time.");
		$display("Test failed");
		$finish;
	end

	task automatic checkValue(input string what, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %0t: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// APB transfer: setup, access, then one idle cycle.
	// --------------------------------------------------
	task automatic transfer(input logic write, input apbAddr_t addr, input word_t wdata,
		input logic expErr, output word_t rdata);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk);
		penable = 1'b1;
		#2;
		while (!pready) begin
			@(negedge clk);
			#2;
		end
		rdata = prdata;
		checks++;
		assert (pslverr === expErr) else begin
			$display("[FAIL] %0t: pslverr %b at address 0x%02h, expected %b",
				$time, pslverr, addr, expErr);
			errors++;
		end
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic readCheck(input apbAddr_t addr, input word_t exp, input string what);
		word_t rd;
		transfer(1'b0, addr, '0, 1'b0, rd);
		checkValue(what, rd, exp);
	endtask

	task automatic writeReg(input regIdx_t idx, input word_t value);
		word_t rd;
		transfer(1'b1, apbAddr_t'(`REG_BASE + 4 * idx), value, 1'b0, rd);
		model[idx] = value;
	endtask

	task automatic checkAll();
		for (int i = 0; i < `REG_COUNT; i++) begin
			readCheck(apbAddr_t'(`REG_BASE + 4 * i), model[i], "register");
		end
		readCheck(`ADDR_FLAGS, word_t'(flagsModel), "status");
	endtask

	// Runs one instruction and updates the model from the flag rules.
	task automatic execOp(input logic [4:0] op, input regIdx_t dIdx, input regIdx_t sIdx);
		word_t       d;
		word_t       s;
		word_t       res;
		word_t       instr;
		word_t       rd;
		flags_t      f;
		logic [16:0] wide;
		int          sd;
		d = model[dIdx];
		s = model[sIdx];
		res = d;
		f = flagsModel;
		instr = {sIdx, dIdx, 3'b000, op};
		case (op)
			OP_ADD: begin
				wide = 17'(d) + 17'(s);
				res = wide[15:0];
				sd = $signed(d) + $signed(s);
				f[`FLAG_C] = wide[16];
				f[`FLAG_F] = (sd > 32767) || (sd < -32768);
			end
			OP_SUB: begin
				res = d - s;
				sd = $signed(d) - $signed(s);
				f[`FLAG_C] = (d >= s);
				f[`FLAG_F] = (sd > 32767) || (sd < -32768);
			end
			OP_AND:  res = d & s;
			OP_OR:   res = d | s;
			OP_XOR:  res = d ^ s;
			OP_NOT:  res = ~s;
			OP_LSH:  res = s << 1;
			OP_RSH:  res = s >> 1;
			OP_ARSH: res = word_t'($signed(s) >>> 1);
			default: res = d;
		endcase
		if (op <= OP_CMP) begin
			f[`FLAG_L] = (d < s);
			f[`FLAG_Z] = (d == s);
			f[`FLAG_N] = ($signed(d) < $signed(s));
		end
		transfer(1'b1, `ADDR_INSTR, instr, 1'b0, rd);
		if (op != OP_CMP) begin
			model[dIdx] = res;
		end
		flagsModel = f;
		lastInstrModel = instr;
		readCheck(apbAddr_t'(`REG_BASE + 4 * dIdx), model[dIdx], "rdest");
		readCheck(`ADDR_FLAGS, word_t'(flagsModel), "status");
		if (op == OP_CMP) begin
			checkAll();
		end
	endtask

	task automatic randomOp(input logic [4:0] op);
		regIdx_t dIdx;
		regIdx_t sIdx;
		dIdx = regIdx_t'($random(seed));
		sIdx = regIdx_t'($random(seed));
		writeReg(dIdx, word_t'($random(seed)));
		writeReg(sIdx, word_t'($random(seed)));
		execOp(op, dIdx, sIdx);
	endtask

	initial begin
		word_t rd;
		seed = 70;
		errors = 0;
		checks = 0;
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		flagsModel = '0;
		lastInstrModel = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			model[i] = '0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Reset state.
		checkAll();
		readCheck(`ADDR_INSTR, '0, "instruction register");

		// Register window.
		for (int i = 0; i < `REG_COUNT; i++) begin
			writeReg(regIdx_t'(i), word_t'($random(seed)));
		end
		checkAll();

		// --------------------------------------------------
		// Arithmetic corner cases, then every opcode.
		// --------------------------------------------------
		writeReg(1, 16'h7fff);
		writeReg(2, 16'h0001);
		execOp(OP_ADD, 1, 2);
		writeReg(3, 16'h8000);
		writeReg(4, 16'h0001);
		execOp(OP_SUB, 3, 4);
		writeReg(6, 16'hffff);
		writeReg(7, 16'h0001);
		execOp(OP_ADD, 6, 7);
		execOp(OP_SUB, 5, 5);
		execOp(OP_CMP, 8, 8);
		writeReg(9, 16'h8001);
		execOp(OP_ARSH, 10, 9);
		for (int op = 0; op <= OP_ARSH; op++) begin
			randomOp(5'(op));
		end
		for (int n = 0; n < numOps; n++) begin
			randomOp(5'($unsigned($random(seed)) % 10));
		end

		// Rejected and ignored accesses.
		transfer(1'b0, 8'h08, '0, 1'b1, rd);
		transfer(1'b1, 8'h80, word_t'($random(seed)), 1'b1, rd);
		transfer(1'b1, 8'h42, word_t'($random(seed)), 1'b1, rd);
		transfer(1'b1, `ADDR_INSTR, {4'd1, 4'd2, 3'b000, 5'd10}, 1'b1, rd);
		transfer(1'b1, `ADDR_INSTR, {4'd3, 4'd4, 3'b000, 5'd31}, 1'b1, rd);
		transfer(1'b1, `ADDR_FLAGS, 16'h001f, 1'b0, rd);
		checkAll();
		readCheck(`ADDR_INSTR, lastInstrModel, "instruction register");

		repeat (2) @(posedge clk);
		errors += dut0.props0.propErrors;
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/aluCore_props.sv */
`default_nettype none

`include "alu_cfg.svh"

module aluCore_props (
	input logic             clk,
	input logic             rstN,
	input logic             psel,
	input logic             penable,
	input logic             pwrite,
	input aluPkg::apbAddr_t paddr,
	input logic             pready,
	input logic             pslverr,
	input aluPkg::flags_t   statusReg
);
	import aluPkg::*;

	// Failures seen so far, read back by the testbench.
	int propErrors = 0;

	// --------------------------------------------------
	// APB handshake.
	// --------------------------------------------------
	apbReady: assert property (@(posedge clk) disable iff (!rstN)
		(psel && penable) |-> pready)
	else begin
		$error("pready is low in an APB access phase");
		propErrors++;
	end

	errOnlyInAccess: assert property (@(posedge clk) disable iff (!rstN)
		!(psel && penable) |-> !pslverr)
	else begin
		$error("pslverr is high outside an APB access phase");
		propErrors++;
	end

	// --------------------------------------------------
	// Status register.
	// --------------------------------------------------
	// Only the edge that completes an instruction write may move the flags.
	statusOnInstr: assert property (@(posedge clk) disable iff (!rstN)
		!(psel && penable && pwrite && (paddr == `ADDR_INSTR)) |=> $stable(statusReg))
	else begin
		$error("status register changed outside an instruction write");
		propErrors++;
	end

endmodule

bind aluCore aluCore_props props0 (
	.clk       (clk),
	.rstN      (rstN),
	.psel      (psel),
	.penable   (penable),
	.pwrite    (pwrite),
	.paddr     (paddr),
	.pready    (pready),
	.pslverr   (pslverr),
	.statusReg (ctrl0.statusReg)
);

`default_nettype wire

/* logic/aluCore.sv */
`default_nettype none

module aluCore (
	input  logic             clk,
	input  logic             rstN,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  aluPkg::apbAddr_t paddr,
	input  aluPkg::word_t    pwdata,
	output aluPkg::word_t    prdata,
	output logic             pready,
	output logic             pslverr
);
	import aluPkg::*;

	regIdx_t rdIdxA;
	regIdx_t rdIdxB;
	word_t   rdDataA;
	word_t   rdDataB;
	logic    wrEn;
	regIdx_t wrIdx;
	word_t   wrData;

	aluIf aluBus ();

	execControl ctrl0 (
		.clk     (clk),
		.rstN    (rstN),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.bus     (aluBus.ctrl),
		.rdIdxA  (rdIdxA),
		.rdIdxB  (rdIdxB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (wrEn),
		.wrIdx   (wrIdx),
		.wrData  (wrData)
	);

	regFile regs0 (
		.clk     (clk),
		.rstN    (rstN),
		.rdIdxA  (rdIdxA),
		.rdIdxB  (rdIdxB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (wrEn),
		.wrIdx   (wrIdx),
		.wrData  (wrData)
	);

	alu alu0 (
		.bus (aluBus.alu)
	);

endmodule

`default_nettype wire

/* logic/execControl.sv */
`default_nettype none

`include "alu_cfg.svh"

module execControl (
	input  logic             clk,
	input  logic             rstN,
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  aluPkg::apbAddr_t paddr,
	input  aluPkg::word_t    pwdata,
	output aluPkg::word_t    prdata,
	output logic             pready,
	output logic             pslverr,
	aluIf.ctrl               bus,
	output aluPkg::regIdx_t  rdIdxA,
	output aluPkg::regIdx_t  rdIdxB,
	input  aluPkg::word_t    rdDataA,
	input  aluPkg::word_t    rdDataB,
	output logic             wrEn,
	output aluPkg::regIdx_t  wrIdx,
	output aluPkg::word_t    wrData
);
	import aluPkg::*;

	logic    accessPhase;
	logic    isInstr;
	logic    isFlags;
	logic    isWindow;
	logic    instrWrite;
	logic    winWrite;
	regIdx_t winIdx;
	flags_t  statusReg;
	word_t   lastInstr;

	// --------------------------------------------------
	// APB address decode.
	// --------------------------------------------------
	assign accessPhase = psel && penable;
	assign isInstr = (paddr == `ADDR_INSTR);
	assign isFlags = (paddr == `ADDR_FLAGS);
	assign isWindow = (paddr >= `REG_BASE) && (paddr < (`REG_BASE + 4 * `REG_COUNT)) &&
		(paddr[1:0] == 2'b00);
	assign winIdx = paddr[`REG_IDX_W+1:2];

	// Zero wait states.
	assign pready = 1'b1;

	assign pslverr = accessPhase && (!(isInstr || isFlags || isWindow) ||
		(pwrite && isInstr && !bus.opValid));

	assign instrWrite = accessPhase && pwrite && isInstr && bus.opValid;
	assign winWrite = accessPhase && pwrite && isWindow;

	// Operand fetch. Port A doubles as the window read and write index.
	assign rdIdxA = isInstr ? pwdata[`RDEST_MSB:`RDEST_LSB] : winIdx;
	assign rdIdxB = pwdata[`RSRC_MSB:`RSRC_LSB];

	assign bus.dst = rdDataA;
	assign bus.src = rdDataB;
	assign bus.opCode = opCode_e'(pwdata[`OP_MSB:`OP_LSB]);

	// Write-back, CMP only sets flags.
	assign wrEn = (instrWrite && (bus.opCode != OP_CMP)) || winWrite;
	assign wrIdx = rdIdxA;
	assign wrData = isInstr ? bus.result : pwdata;

	// --------------------------------------------------
	// Status and last instruction.
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			statusReg <= '0;
			lastInstr <= '0;
		end else if (instrWrite) begin
			statusReg <= (statusReg & ~bus.flagMask) | (bus.flags & bus.flagMask);
			lastInstr <= pwdata;
		end
	end

	// Read data only during a read access phase.
	always_comb begin
		prdata = '0;
		if (accessPhase && !pwrite) begin
			if (isInstr) begin
				prdata = lastInstr;
			end else if (isFlags) begin
				prdata = word_t'(statusReg);
			end else if (isWindow) begin
				prdata = rdDataA;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`default_nettype none

`include "alu_cfg.svh"

module regFile (
	input  logic            clk,
	input  logic            rstN,
	input  aluPkg::regIdx_t rdIdxA,
	input  aluPkg::regIdx_t rdIdxB,
	output aluPkg::word_t   rdDataA,
	output aluPkg::word_t   rdDataB,
	input  logic            wrEn,
	input  aluPkg::regIdx_t wrIdx,
	input  aluPkg::word_t   wrData
);
	import aluPkg::*;

	word_t regs [`REG_COUNT];

	// --------------------------------------------------
	// Write port.
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

	// Both reads are combinational, so a write shows up next cycle.
	assign rdDataA = regs[rdIdxA];
	assign rdDataB = regs[rdIdxB];

endmodule

`default_nettype wire

/* logic/alu.sv */
`default_nettype none

`include "alu_cfg.svh"

module alu (
	aluIf.alu bus
);
	import aluPkg::*;

	// CMP only touches the compare flags.
	localparam flags_t cmpFlagMask = flags_t'((1 << `FLAG_L) | (1 << `FLAG_Z) |
		(1 << `FLAG_N));

	word_t  addSrc;
	logic   addCin;
	word_t  addSum;
	flags_t addFlags;

	addSub adder0 (
		.rdest (bus.dst),
		.rsrc  (addSrc),
		.cin   (addCin),
		.sum   (addSum),
		.flags (addFlags)
	);

	// The flag values always come from the adder; the mask decides use.
	assign bus.flags = addFlags;

	assign bus.opValid = (bus.opCode <= OP_ARSH);

	// --------------------------------------------------
	// Operation decode and result select.
	// --------------------------------------------------
	always_comb begin
		addSrc = bus.src;
		addCin = 1'b0;
		bus.result = '0;
		bus.flagMask = '0;
		case (bus.opCode)
			OP_ADD: begin
				bus.result = addSum;
				bus.flagMask = '1;
			end
			OP_SUB: begin
				addSrc = ~bus.src;
				addCin = 1'b1;
				bus.result = addSum;
				bus.flagMask = '1;
			end
			OP_CMP: begin
				// Same datapath as SUB, the result is discarded.
				addSrc = ~bus.src;
				addCin = 1'b1;
				bus.result = addSum;
				bus.flagMask = cmpFlagMask;
			end
			OP_AND:  bus.result = bus.dst & bus.src;
			OP_OR:   bus.result = bus.dst | bus.src;
			OP_XOR:  bus.result = bus.dst ^ bus.src;
			OP_NOT:  bus.result = ~bus.src;
			OP_LSH:  bus.result = {bus.src[`DATA_W-2:0], 1'b0};
			OP_RSH:  bus.result = {1'b0, bus.src[`DATA_W-1:1]};
			// Sign bit is copied into the vacated top bit.
			OP_ARSH: bus.result = {bus.src[`DATA_W-1], bus.src[`DATA_W-1:1]};
			default: begin
				bus.result = '0;
				bus.flagMask = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/addSub.sv */
`default_nettype none

`include "alu_cfg.svh"

module addSub (
	input  aluPkg::word_t  rdest,
	input  aluPkg::word_t  rsrc,
	input  logic           cin,
	output aluPkg::word_t  sum,
	output aluPkg::flags_t flags
);
	import aluPkg::*;

	word_t srcTrue;
	logic  carryOut;
	logic  overflow;

	// A set carry-in marks a subtraction, where rsrc arrives inverted.
	assign srcTrue = cin ? ~rsrc : rsrc;

	assign {carryOut, sum} = rdest + rsrc + cin;

	// Same-sign inputs giving a result of the other sign.
	assign overflow = (rdest[`DATA_W-1] == rsrc[`DATA_W-1]) &&
		(sum[`DATA_W-1] != rdest[`DATA_W-1]);

	always_comb begin
		flags = '0;
		flags[`FLAG_C] = carryOut;
		flags[`FLAG_F] = overflow;
		// Compare flags look at the operands, not the sum.
		flags[`FLAG_L] = rdest < srcTrue;
		flags[`FLAG_Z] = rdest == srcTrue;
		flags[`FLAG_N] = $signed(rdest) < $signed(srcTrue);
	end

endmodule

`default_nettype wire

/* logic/aluIf.sv */
`default_nettype none

interface aluIf;
	import aluPkg::*;

	// Operands and operation from the control block.
	word_t   src;
	word_t   dst;
	opCode_e opCode;

	// Combinational answer from the ALU.
	word_t   result;
	flags_t  flags;
	flags_t  flagMask;
	logic    opValid;

	modport ctrl (
		output src, dst, opCode,
		input  result, flags, flagMask, opValid
	);

	modport alu (
		input  src, dst, opCode,
		output result, flags, flagMask, opValid
	);

endinterface

`default_nettype wire

/* logic/aluPkg.sv */
`default_nettype none

`include "alu_cfg.svh"

package aluPkg;

	// Register or operand value.
	typedef logic [`DATA_W-1:0] word_t;

	// Register number.
	typedef logic [`REG_IDX_W-1:0] regIdx_t;

	// Flag set or flag mask, indexed by the FLAG_* positions.
	typedef logic [`FLAG_N:0] flags_t;

	// APB byte address.
	typedef logic [`APB_ADDR_W-1:0] apbAddr_t;

	// ALU operation codes, as found in the low bits of an instruction.
	typedef enum logic [4:0] {
		OP_ADD  = 5'd0,
		OP_SUB,
		OP_CMP,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOT,
		OP_LSH,
		OP_RSH,
		OP_ARSH = 5'd9
	} opCode_e;

endpackage

`default_nettype wire

/* logic/alu_cfg.svh */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Datapath and register file sizes.
`define DATA_W      16
`define REG_COUNT   16
`define REG_IDX_W   4

// APB address map.
`define APB_ADDR_W  8
`define ADDR_INSTR  8'h00
`define ADDR_FLAGS  8'h04
`define REG_BASE    8'h40

// Status register bit positions.
`define FLAG_C      0
`define FLAG_L      1
`define FLAG_F      2
`define FLAG_Z      3
`define FLAG_N      4

// Instruction word fields.
`define OP_MSB      4
`define OP_LSB      0
`define RDEST_MSB   11
`define RDEST_LSB   8
`define RSRC_MSB    15
`define RSRC_LSB    12

`endif
